//--- hw/rv_ctrl_pkg.sv
////////////////////
// Shared encodings for the RV32I control path
// Imported by the RTL and the testbench
////////////////////

package rv_ctrl_pkg;

	// Field widths
	localparam int INSTR_W    = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 7;
	localparam int FUNCT3_W   = 3;

	// Major opcodes, bits [6:0]
	typedef enum logic [OPCODE_W-1:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_IMM    = 7'b0010011,
		OPC_R      = 7'b0110011
	} opcode_e;

	// Branch funct3
	localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

	// ALU funct3, shared by OP_IMM and OP_R
	localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
	localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

	// ALU and compare operations
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9,
		ALU_SEQ  = 4'd10,
		ALU_SNE  = 4'd11,
		ALU_SGE  = 4'd12,
		ALU_SGEU = 4'd13
	} alu_op_e;

	// Operand A source
	typedef enum logic [1:0] {
		A_RS1  = 2'd0,
		A_PC   = 2'd1,
		A_ZERO = 2'd2
	} a_sel_e;

	// Operand B source
	typedef enum logic [1:0] {
		B_RS2  = 2'd0,
		B_IMM  = 2'd1,
		B_FOUR = 2'd2
	} b_sel_e;

	// Immediate format, B and J live in the branch adder
	typedef enum logic [1:0] {
		IMM_I = 2'd0,
		IMM_S = 2'd1,
		IMM_U = 2'd2
	} imm_sel_e;

	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MEM = 1'b1
	} wb_sel_e;

	// Next PC source
	typedef enum logic [1:0] {
		PC_FOUR   = 2'd0,
		PC_BRANCH = 2'd1,
		PC_JAL    = 2'd2,
		PC_JALR   = 2'd3
	} pc_sel_e;

	// EXE means the register file value read in decode
	typedef enum logic [1:0] {
		FWD_EXE = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_e;

endpackage

//--- hw/instr_decoder.sv
////////////////////
// Decode-stage control for one RV32I instruction
// Pure combinational, feeds fetch and the control pipeline
////////////////////

`timescale 1ns/1ps

module instr_decoder (
	input  logic [rv_ctrl_pkg::INSTR_W-1:0]    instr,
	input  logic                               instr_valid,
	input  logic                               br_true,
	output rv_ctrl_pkg::imm_sel_e              imm_sel,
	output rv_ctrl_pkg::alu_op_e               br_op,
	output rv_ctrl_pkg::pc_sel_e               pc_sel,
	output logic                               flush_if,
	output rv_ctrl_pkg::a_sel_e                a_sel,
	output rv_ctrl_pkg::b_sel_e                b_sel,
	output rv_ctrl_pkg::alu_op_e               alu_op,
	output logic                               mem_en,
	output logic                               mem_wr,
	output rv_ctrl_pkg::wb_sel_e               wb_sel,
	output logic                               reg_en,
	output logic                               uses_rs1,
	output logic                               uses_rs2,
	output logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rd_addr_dec,
	output logic                               illegal_instr
);
	import rv_ctrl_pkg::*;

	opcode_e             opcode;
	logic [FUNCT3_W-1:0] funct3;
	logic                funct7_alt;
	alu_op_e             alu_fn;
	logic                is_branch;
	logic                is_jal;
	logic                is_jalr;

	assign opcode     = opcode_e'(instr[6:0]);
	assign funct3     = instr[14:12];
	assign funct7_alt = instr[30];

	// ALU function, SUB only exists for register ops
	always_comb begin
		case (funct3)
			F3_ADD_SUB: alu_fn = (funct7_alt && opcode == OPC_R) ? ALU_SUB : ALU_ADD;
			F3_SLL:     alu_fn = ALU_SLL;
			F3_SLT:     alu_fn = ALU_SLT;
			F3_SLTU:    alu_fn = ALU_SLTU;
			F3_XOR:     alu_fn = ALU_XOR;
			F3_SRL_SRA: alu_fn = funct7_alt ? ALU_SRA : ALU_SRL;
			F3_OR:      alu_fn = ALU_OR;
			default:    alu_fn = ALU_AND;
		endcase
	end

	always_comb begin
		// Idle defaults, match a bubble
		imm_sel       = IMM_I;
		br_op         = ALU_SEQ;
		a_sel         = A_RS1;
		b_sel         = B_IMM;
		alu_op        = ALU_ADD;
		mem_en        = 1'b0;
		mem_wr        = 1'b0;
		wb_sel        = WB_ALU;
		reg_en        = 1'b0;
		uses_rs1      = 1'b0;
		uses_rs2      = 1'b0;
		is_branch     = 1'b0;
		is_jal        = 1'b0;
		is_jalr       = 1'b0;
		illegal_instr = 1'b0;

		case (opcode)
			OPC_LUI: begin
				a_sel   = A_ZERO;
				imm_sel = IMM_U;
				reg_en  = 1'b1;
			end
			OPC_AUIPC: begin
				a_sel   = A_PC;
				imm_sel = IMM_U;
				reg_en  = 1'b1;
			end
			// Link value is PC + 4
			OPC_JAL: begin
				a_sel  = A_PC;
				b_sel  = B_FOUR;
				reg_en = 1'b1;
				is_jal = 1'b1;
			end
			OPC_JALR: begin
				a_sel         = A_PC;
				b_sel         = B_FOUR;
				reg_en        = 1'b1;
				uses_rs1      = 1'b1;
				is_jalr       = 1'b1;
				illegal_instr = (funct3 != '0);
			end
			OPC_BRANCH: begin
				b_sel     = B_RS2;
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
				is_branch = 1'b1;
				case (funct3)
					F3_BEQ:  br_op = ALU_SEQ;
					F3_BNE:  br_op = ALU_SNE;
					F3_BLT:  br_op = ALU_SLT;
					F3_BGE:  br_op = ALU_SGE;
					F3_BLTU: br_op = ALU_SLTU;
					F3_BGEU: br_op = ALU_SGEU;
					default: illegal_instr = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				mem_en   = 1'b1;
				wb_sel   = WB_MEM;
				reg_en   = 1'b1;
				uses_rs1 = 1'b1;
			end
			OPC_STORE: begin
				imm_sel  = IMM_S;
				mem_en   = 1'b1;
				mem_wr   = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			OPC_IMM: begin
				alu_op   = alu_fn;
				reg_en   = 1'b1;
				uses_rs1 = 1'b1;
			end
			OPC_R: begin
				b_sel    = B_RS2;
				alu_op   = alu_fn;
				reg_en   = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			default: illegal_instr = 1'b1;
		endcase
	end

	// Stores and branches carry no destination
	assign rd_addr_dec = (opcode == OPC_STORE || opcode == OPC_BRANCH) ? '0 : instr[11:7];

	// Redirect priority, illegal encodings never redirect
	always_comb begin
		pc_sel = PC_FOUR;
		if (instr_valid && !illegal_instr) begin
			if (is_branch && br_true)
				pc_sel = PC_BRANCH;
			else if (is_jal)
				pc_sel = PC_JAL;
			else if (is_jalr)
				pc_sel = PC_JALR;
		end
	end

	assign flush_if = (pc_sel != PC_FOUR);

endmodule

//--- hw/hazard_unit.sv
////////////////////
// Load-use stall and operand forwarding selection
////////////////////

`timescale 1ns/1ps

module hazard_unit (
	input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rs1_dec,
	input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rs2_dec,
	input  logic                               uses_rs1,
	input  logic                               uses_rs2,
	input  logic                               instr_valid,
	input  logic                               load_exe,
	input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rd_exe,
	input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rs1_exe,
	input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rs2_exe,
	input  logic                               reg_en_mem,
	input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rd_mem,
	input  logic                               reg_en_wb,
	input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rd_wb,
	output logic                               stall,
	output rv_ctrl_pkg::fwd_sel_e              fwd_a_sel,
	output rv_ctrl_pkg::fwd_sel_e              fwd_b_sel
);
	import rv_ctrl_pkg::*;

	// Youngest writer wins, x0 is never a producer
	function automatic fwd_sel_e pick_fwd(
		input logic [REG_ADDR_W-1:0] rs,
		input logic                  en_mem,
		input logic [REG_ADDR_W-1:0] dst_mem,
		input logic                  en_wb,
		input logic [REG_ADDR_W-1:0] dst_wb
	);
		if (en_mem && dst_mem != '0 && dst_mem == rs)
			return FWD_MEM;
		else if (en_wb && dst_wb != '0 && dst_wb == rs)
			return FWD_WB;
		else
			return FWD_EXE;
	endfunction

	logic hit_rs1;
	logic hit_rs2;

	// Load result not ready until after memory
	assign hit_rs1 = uses_rs1 && (rs1_dec == rd_exe);
	assign hit_rs2 = uses_rs2 && (rs2_dec == rd_exe);
	assign stall   = instr_valid && load_exe && (rd_exe != '0) && (hit_rs1 || hit_rs2);

	always_comb begin
		fwd_a_sel = pick_fwd(rs1_exe, reg_en_mem, rd_mem, reg_en_wb, rd_wb);
		fwd_b_sel = pick_fwd(rs2_exe, reg_en_mem, rd_mem, reg_en_wb, rd_wb);
	end

endmodule

//--- hw/ctrl_pipe.sv
////////////////////
// ID/EX, EX/MEM and MEM/WB control registers
// Bubble loads idle values into ID/EX, later stages always advance
////////////////////

`timescale 1ns/1ps

module ctrl_pipe (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               bubble,
	input  rv_ctrl_pkg::a_sel_e                a_sel,
	input  rv_ctrl_pkg::b_sel_e                b_sel,
	input  rv_ctrl_pkg::alu_op_e               alu_op,
	input  logic                               mem_en,
	input  logic                               mem_wr,
	input  rv_ctrl_pkg::wb_sel_e               wb_sel,
	input  logic                               reg_en,
	input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rs1_dec,
	input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rs2_dec,
	input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rd_addr_dec,
	output rv_ctrl_pkg::a_sel_e                a_sel_exe,
	output rv_ctrl_pkg::b_sel_e                b_sel_exe,
	output rv_ctrl_pkg::alu_op_e               alu_op_exe,
	output logic                               load_exe,
	output logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rd_exe,
	output logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rs1_exe,
	output logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rs2_exe,
	output logic                               mem_en_mem,
	output logic                               mem_wr_mem,
	output logic                               reg_en_mem,
	output logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rd_mem,
	output rv_ctrl_pkg::wb_sel_e               wb_sel_wb,
	output logic                               reg_en_wb,
	output logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rd_wb
);
	import rv_ctrl_pkg::*;

	// Fields still in flight past execute
	logic    mem_en_exe;
	logic    mem_wr_exe;
	wb_sel_e wb_sel_exe;
	logic    reg_en_exe;
	wb_sel_e wb_sel_mem;

	// ID/EX
	always_ff @(posedge clk) begin
		if (reset || bubble) begin
			a_sel_exe  <= A_RS1;
			b_sel_exe  <= B_IMM;
			alu_op_exe <= ALU_ADD;
			mem_en_exe <= 1'b0;
			mem_wr_exe <= 1'b0;
			wb_sel_exe <= WB_ALU;
			reg_en_exe <= 1'b0;
			rs1_exe    <= '0;
			rs2_exe    <= '0;
			rd_exe     <= '0;
		end else begin
			a_sel_exe  <= a_sel;
			b_sel_exe  <= b_sel;
			alu_op_exe <= alu_op;
			mem_en_exe <= mem_en;
			mem_wr_exe <= mem_wr;
			wb_sel_exe <= wb_sel;
			reg_en_exe <= reg_en;
			rs1_exe    <= rs1_dec;
			rs2_exe    <= rs2_dec;
			rd_exe     <= rd_addr_dec;
		end
	end

	assign load_exe = mem_en_exe && !mem_wr_exe;

	// EX/MEM, operand selects dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			mem_en_mem <= 1'b0;
			mem_wr_mem <= 1'b0;
			wb_sel_mem <= WB_ALU;
			reg_en_mem <= 1'b0;
			rd_mem     <= '0;
		end else begin
			mem_en_mem <= mem_en_exe;
			mem_wr_mem <= mem_wr_exe;
			wb_sel_mem <= wb_sel_exe;
			reg_en_mem <= reg_en_exe;
			rd_mem     <= rd_exe;
		end
	end

	// MEM/WB, only write-back fields remain
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_sel_wb <= WB_ALU;
			reg_en_wb <= 1'b0;
			rd_wb     <= '0;
		end else begin
			wb_sel_wb <= wb_sel_mem;
			reg_en_wb <= reg_en_mem;
			rd_wb     <= rd_mem;
		end
	end

endmodule

//--- hw/pipeline_control.sv
////////////////////
// Control path top for the five-stage RV32I pipeline
////////////////////

`timescale 1ns/1ps

module pipeline_control (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [rv_ctrl_pkg::INSTR_W-1:0] instr,
	input  logic                            instr_valid,
	input  logic                            br_true,
	output logic                            instr_ready,
	output rv_ctrl_pkg::pc_sel_e            pc_sel,
	output logic                            flush_if,
	output rv_ctrl_pkg::imm_sel_e           imm_sel,
	output rv_ctrl_pkg::alu_op_e            br_op,
	output rv_ctrl_pkg::a_sel_e             a_sel_exe,
	output rv_ctrl_pkg::b_sel_e             b_sel_exe,
	output rv_ctrl_pkg::alu_op_e            alu_op_exe,
	output logic                            mem_en_mem,
	output logic                            mem_wr_mem,
	output rv_ctrl_pkg::wb_sel_e            wb_sel_wb,
	output logic                            reg_en_wb,
	output rv_ctrl_pkg::fwd_sel_e           fwd_a_sel,
	output rv_ctrl_pkg::fwd_sel_e           fwd_b_sel,
	output logic                            illegal_instr
);
	import rv_ctrl_pkg::*;

	// Decode-stage controls
	a_sel_e                a_sel_dec;
	b_sel_e                b_sel_dec;
	alu_op_e               alu_op_dec;
	logic                  mem_en_dec;
	logic                  mem_wr_dec;
	wb_sel_e               wb_sel_dec;
	logic                  reg_en_dec;
	logic                  uses_rs1;
	logic                  uses_rs2;
	logic [REG_ADDR_W-1:0] rs1_dec;
	logic [REG_ADDR_W-1:0] rs2_dec;
	logic [REG_ADDR_W-1:0] rd_addr_dec;

	// Tracked stage state
	logic                  load_exe;
	logic [REG_ADDR_W-1:0] rd_exe;
	logic [REG_ADDR_W-1:0] rs1_exe;
	logic [REG_ADDR_W-1:0] rs2_exe;
	logic                  reg_en_mem;
	logic [REG_ADDR_W-1:0] rd_mem;
	logic [REG_ADDR_W-1:0] rd_wb;

	logic stall;
	logic bubble;

	assign rs1_dec     = instr[19:15];
	assign rs2_dec     = instr[24:20];
	assign instr_ready = !stall;
	assign bubble      = stall || !instr_valid || illegal_instr;

	instr_decoder u_decoder (
		.instr         (instr),
		.instr_valid   (instr_valid),
		.br_true       (br_true),
		.imm_sel       (imm_sel),
		.br_op         (br_op),
		.pc_sel        (pc_sel),
		.flush_if      (flush_if),
		.a_sel         (a_sel_dec),
		.b_sel         (b_sel_dec),
		.alu_op        (alu_op_dec),
		.mem_en        (mem_en_dec),
		.mem_wr        (mem_wr_dec),
		.wb_sel        (wb_sel_dec),
		.reg_en        (reg_en_dec),
		.uses_rs1      (uses_rs1),
		.uses_rs2      (uses_rs2),
		.rd_addr_dec   (rd_addr_dec),
		.illegal_instr (illegal_instr)
	);

	hazard_unit u_hazard (
		.rs1_dec     (rs1_dec),
		.rs2_dec     (rs2_dec),
		.uses_rs1    (uses_rs1),
		.uses_rs2    (uses_rs2),
		.instr_valid (instr_valid),
		.load_exe    (load_exe),
		.rd_exe      (rd_exe),
		.rs1_exe     (rs1_exe),
		.rs2_exe     (rs2_exe),
		.reg_en_mem  (reg_en_mem),
		.rd_mem      (rd_mem),
		.reg_en_wb   (reg_en_wb),
		.rd_wb       (rd_wb),
		.stall       (stall),
		.fwd_a_sel   (fwd_a_sel),
		.fwd_b_sel   (fwd_b_sel)
	);

	ctrl_pipe u_pipe (
		.clk         (clk),
		.reset       (reset),
		.bubble      (bubble),
		.a_sel       (a_sel_dec),
		.b_sel       (b_sel_dec),
		.alu_op      (alu_op_dec),
		.mem_en      (mem_en_dec),
		.mem_wr      (mem_wr_dec),
		.wb_sel      (wb_sel_dec),
		.reg_en      (reg_en_dec),
		.rs1_dec     (rs1_dec),
		.rs2_dec     (rs2_dec),
		.rd_addr_dec (rd_addr_dec),
		.a_sel_exe   (a_sel_exe),
		.b_sel_exe   (b_sel_exe),
		.alu_op_exe  (alu_op_exe),
		.load_exe    (load_exe),
		.rd_exe      (rd_exe),
		.rs1_exe     (rs1_exe),
		.rs2_exe     (rs2_exe),
		.mem_en_mem  (mem_en_mem),
		.mem_wr_mem  (mem_wr_mem),
		.reg_en_mem  (reg_en_mem),
		.rd_mem      (rd_mem),
		.wb_sel_wb   (wb_sel_wb),
		.reg_en_wb   (reg_en_wb),
		.rd_wb       (rd_wb)
	);

endmodule

//--- sim/pipeline_control_assertions.sv
////////////////////
// Handshake and pipeline invariants, bound to the control top
////////////////////

`timescale 1ns/1ps

module pipeline_control_assertions (
	input logic                 clk,
	input logic                 reset,
	input logic                 instr_valid,
	input logic                 instr_ready,
	input logic                 flush_if,
	input rv_ctrl_pkg::pc_sel_e pc_sel,
	input logic                 mem_en_mem,
	input logic                 mem_wr_mem
);
	import rv_ctrl_pkg::*;

	// Upstream keeps a stalled instruction offered
	valid_held: assert property (@(posedge clk) disable iff (reset)
		instr_valid && !instr_ready |=> instr_valid)
		else $error("instr_valid dropped while decode was stalled");

	// Load-use stall is a single cycle
	stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
		!instr_ready |=> instr_ready)
		else $error("instr_ready low for two cycles in a row");

	flush_redirects: assert property (@(posedge clk) disable iff (reset)
		flush_if |-> pc_sel != PC_FOUR)
		else $error("flush_if raised without a PC redirect");

	store_has_enable: assert property (@(posedge clk) disable iff (reset)
		mem_wr_mem |-> mem_en_mem)
		else $error("mem_wr_mem high while mem_en_mem is low");

endmodule

bind pipeline_control pipeline_control_assertions u_assertions (
	.clk         (clk),
	.reset       (reset),
	.instr_valid (instr_valid),
	.instr_ready (instr_ready),
	.flush_if    (flush_if),
	.pc_sel      (pc_sel),
	.mem_en_mem  (mem_en_mem),
	.mem_wr_mem  (mem_wr_mem)
);

//--- sim/pipeline_control_tb.sv
////////////////////
// Random-instruction testbench for the RV32I control path
// Checks every cycle against a shadow decode and pipeline model
////////////////////

`timescale 1ns/1ps

module pipeline_control_tb;
	import rv_ctrl_pkg::*;

	localparam int NUM_INSTR  = 3000;
	localparam int HOLD_LIMIT = 8;

	logic               clk;
	logic               reset;
	logic [INSTR_W-1:0] instr;
	logic               instr_valid;
	logic               br_true;
	logic               instr_ready;
	pc_sel_e            pc_sel;
	logic               flush_if;
	imm_sel_e           imm_sel;
	alu_op_e            br_op;
	a_sel_e             a_sel_exe;
	b_sel_e             b_sel_exe;
	alu_op_e            alu_op_exe;
	logic               mem_en_mem;
	logic               mem_wr_mem;
	wb_sel_e            wb_sel_wb;
	logic               reg_en_wb;
	fwd_sel_e           fwd_a_sel;
	fwd_sel_e           fwd_b_sel;
	logic               illegal_instr;

	integer seed;
	int     stall_count;

	// Model decode of the current instruction
	imm_sel_e              d_imm;
	alu_op_e               d_br;
	pc_sel_e               d_pc;
	logic                  d_flush;
	a_sel_e                d_a;
	b_sel_e                d_b;
	alu_op_e               d_alu;
	logic                  d_mem_en;
	logic                  d_mem_wr;
	wb_sel_e               d_wb;
	logic                  d_reg_en;
	logic                  d_uses1;
	logic                  d_uses2;
	logic [REG_ADDR_W-1:0] d_rd;
	logic                  d_ill;

	// Shadow stage registers
	a_sel_e                e_a;
	b_sel_e                e_b;
	alu_op_e               e_alu;
	logic                  e_mem_en;
	logic                  e_mem_wr;
	wb_sel_e               e_wb;
	logic                  e_reg_en;
	logic [REG_ADDR_W-1:0] e_rs1;
	logic [REG_ADDR_W-1:0] e_rs2;
	logic [REG_ADDR_W-1:0] e_rd;
	logic                  m_mem_en;
	logic                  m_mem_wr;
	wb_sel_e               m_wb;
	logic                  m_reg_en;
	logic [REG_ADDR_W-1:0] m_rd;
	wb_sel_e               w_wb;
	logic                  w_reg_en;
	logic [REG_ADDR_W-1:0] w_rd;

	pipeline_control uut (
		.clk           (clk),
		.reset         (reset),
		.instr         (instr),
		.instr_valid   (instr_valid),
		.br_true       (br_true),
		.instr_ready   (instr_ready),
		.pc_sel        (pc_sel),
		.flush_if      (flush_if),
		.imm_sel       (imm_sel),
		.br_op         (br_op),
		.a_sel_exe     (a_sel_exe),
		.b_sel_exe     (b_sel_exe),
		.alu_op_exe    (alu_op_exe),
		.mem_en_mem    (mem_en_mem),
		.mem_wr_mem    (mem_wr_mem),
		.wb_sel_wb     (wb_sel_wb),
		.reg_en_wb     (reg_en_wb),
		.fwd_a_sel     (fwd_a_sel),
		.fwd_b_sel     (fwd_b_sel),
		.illegal_instr (illegal_instr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_on_failure(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic check_ready(input logic got, input logic exp);
		if (got !== exp)
			stop_on_failure($sformatf("ERROR: instr_ready got 0x%0h expected 0x%0h", got, exp));
	endtask

	task automatic check_fetch(input pc_sel_e got_pc, input logic got_flush,
		input pc_sel_e exp_pc, input logic exp_flush);
		if (got_pc !== exp_pc)
			stop_on_failure($sformatf("ERROR: pc_sel got 0x%0h expected 0x%0h", got_pc, exp_pc));
		if (got_flush !== exp_flush)
			stop_on_failure($sformatf("ERROR: flush_if got 0x%0h expected 0x%0h",
				got_flush, exp_flush));
	endtask

	task automatic check_decode(input imm_sel_e got_imm, input alu_op_e got_br,
		input logic got_ill, input imm_sel_e exp_imm, input alu_op_e exp_br, input logic exp_ill);
		if (got_imm !== exp_imm)
			stop_on_failure($sformatf("ERROR: imm_sel got 0x%0h expected 0x%0h", got_imm, exp_imm));
		if (got_br !== exp_br)
			stop_on_failure($sformatf("ERROR: br_op got 0x%0h expected 0x%0h", got_br, exp_br));
		if (got_ill !== exp_ill)
			stop_on_failure($sformatf("ERROR: illegal_instr got 0x%0h expected 0x%0h",
				got_ill, exp_ill));
	endtask

	task automatic check_exe(input a_sel_e got_a, input b_sel_e got_b, input alu_op_e got_alu);
		if (got_a !== e_a)
			stop_on_failure($sformatf("ERROR: a_sel_exe got 0x%0h expected 0x%0h", got_a, e_a));
		if (got_b !== e_b)
			stop_on_failure($sformatf("ERROR: b_sel_exe got 0x%0h expected 0x%0h", got_b, e_b));
		if (got_alu !== e_alu)
			stop_on_failure($sformatf("ERROR: alu_op_exe got 0x%0h expected 0x%0h", got_alu, e_alu));
	endtask

	task automatic check_mem(input logic got_en, input logic got_wr);
		if (got_en !== m_mem_en)
			stop_on_failure($sformatf("ERROR: mem_en_mem got 0x%0h expected 0x%0h", got_en, m_mem_en));
		if (got_wr !== m_mem_wr)
			stop_on_failure($sformatf("ERROR: mem_wr_mem got 0x%0h expected 0x%0h", got_wr, m_mem_wr));
	endtask

	task automatic check_wb(input wb_sel_e got_sel, input logic got_en);
		if (got_sel !== w_wb)
			stop_on_failure($sformatf("ERROR: wb_sel_wb got 0x%0h expected 0x%0h", got_sel, w_wb));
		if (got_en !== w_reg_en)
			stop_on_failure($sformatf("ERROR: reg_en_wb got 0x%0h expected 0x%0h", got_en, w_reg_en));
	endtask

	task automatic check_fwd(input string name, input fwd_sel_e got, input fwd_sel_e exp);
		if (got !== exp)
			stop_on_failure($sformatf("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	function automatic alu_op_e expected_alu(input logic [2:0] f3, input logic alt,
		input logic reg_op);
		case (f3)
			F3_ADD_SUB: return (alt && reg_op) ? ALU_SUB : ALU_ADD;
			F3_SLL:     return ALU_SLL;
			F3_SLT:     return ALU_SLT;
			F3_SLTU:    return ALU_SLTU;
			F3_XOR:     return ALU_XOR;
			F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
			F3_OR:      return ALU_OR;
			default:    return ALU_AND;
		endcase
	endfunction

	// Memory stage beats write-back, x0 never forwards
	function automatic fwd_sel_e expected_fwd(input logic [REG_ADDR_W-1:0] rs);
		if (m_reg_en && m_rd != '0 && m_rd == rs)
			return FWD_MEM;
		if (w_reg_en && w_rd != '0 && w_rd == rs)
			return FWD_WB;
		return FWD_EXE;
	endfunction

	task automatic predict_decode(input logic [INSTR_W-1:0] ins, input logic v, input logic bt);
		logic [6:0] opc;
		logic [2:0] f3;
		opc      = ins[6:0];
		f3       = ins[14:12];
		d_imm    = IMM_I;
		d_br     = ALU_SEQ;
		d_a      = A_RS1;
		d_b      = B_IMM;
		d_alu    = ALU_ADD;
		d_mem_en = 1'b0;
		d_mem_wr = 1'b0;
		d_wb     = WB_ALU;
		d_reg_en = 1'b0;
		d_uses1  = 1'b0;
		d_uses2  = 1'b0;
		d_ill    = 1'b0;
		d_pc     = PC_FOUR;
		case (opc)
			OPC_LUI: begin
				d_a      = A_ZERO;
				d_imm    = IMM_U;
				d_reg_en = 1'b1;
			end
			OPC_AUIPC: begin
				d_a      = A_PC;
				d_imm    = IMM_U;
				d_reg_en = 1'b1;
			end
			OPC_JAL: begin
				d_a      = A_PC;
				d_b      = B_FOUR;
				d_reg_en = 1'b1;
				d_pc     = PC_JAL;
			end
			OPC_JALR: begin
				d_a      = A_PC;
				d_b      = B_FOUR;
				d_reg_en = 1'b1;
				d_uses1  = 1'b1;
				d_ill    = (f3 != 3'b000);
				d_pc     = PC_JALR;
			end
			OPC_BRANCH: begin
				d_b     = B_RS2;
				d_uses1 = 1'b1;
				d_uses2 = 1'b1;
				d_pc    = bt ? PC_BRANCH : PC_FOUR;
				case (f3)
					F3_BEQ:  d_br = ALU_SEQ;
					F3_BNE:  d_br = ALU_SNE;
					F3_BLT:  d_br = ALU_SLT;
					F3_BGE:  d_br = ALU_SGE;
					F3_BLTU: d_br = ALU_SLTU;
					F3_BGEU: d_br = ALU_SGEU;
					default: d_ill = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				d_mem_en = 1'b1;
				d_wb     = WB_MEM;
				d_reg_en = 1'b1;
				d_uses1  = 1'b1;
			end
			OPC_STORE: begin
				d_imm    = IMM_S;
				d_mem_en = 1'b1;
				d_mem_wr = 1'b1;
				d_uses1  = 1'b1;
				d_uses2  = 1'b1;
			end
			OPC_IMM: begin
				d_alu    = expected_alu(f3, ins[30], 1'b0);
				d_reg_en = 1'b1;
				d_uses1  = 1'b1;
			end
			OPC_R: begin
				d_b      = B_RS2;
				d_alu    = expected_alu(f3, ins[30], 1'b1);
				d_reg_en = 1'b1;
				d_uses1  = 1'b1;
				d_uses2  = 1'b1;
			end
			default: d_ill = 1'b1;
		endcase
		// Only a valid legal redirect leaves PC + 4
		if (!v || d_ill)
			d_pc = PC_FOUR;
		d_flush = (d_pc != PC_FOUR);
		d_rd = (opc == OPC_STORE || opc == OPC_BRANCH) ? 5'd0 : ins[11:7];
	endtask

	task automatic clear_exe();
		e_a      = A_RS1;
		e_b      = B_IMM;
		e_alu    = ALU_ADD;
		e_mem_en = 1'b0;
		e_mem_wr = 1'b0;
		e_wb     = WB_ALU;
		e_reg_en = 1'b0;
		e_rs1    = '0;
		e_rs2    = '0;
		e_rd     = '0;
	endtask

	task automatic reset_model();
		clear_exe();
		m_mem_en = 1'b0;
		m_mem_wr = 1'b0;
		m_wb     = WB_ALU;
		m_reg_en = 1'b0;
		m_rd     = '0;
		w_wb     = WB_ALU;
		w_reg_en = 1'b0;
		w_rd     = '0;
	endtask

	// Oldest stage first so each one takes the previous contents
	task automatic advance_model(input logic bubble, input logic [INSTR_W-1:0] ins);
		w_wb     = m_wb;
		w_reg_en = m_reg_en;
		w_rd     = m_rd;
		m_mem_en = e_mem_en;
		m_mem_wr = e_mem_wr;
		m_wb     = e_wb;
		m_reg_en = e_reg_en;
		m_rd     = e_rd;
		if (bubble) begin
			clear_exe();
		end else begin
			e_a      = d_a;
			e_b      = d_b;
			e_alu    = d_alu;
			e_mem_en = d_mem_en;
			e_mem_wr = d_mem_wr;
			e_wb     = d_wb;
			e_reg_en = d_reg_en;
			e_rs1    = ins[19:15];
			e_rs2    = ins[24:20];
			e_rd     = d_rd;
		end
	endtask

	task automatic check_cycle(output logic ready);
		logic exp_stall;
		predict_decode(instr, instr_valid, br_true);
		exp_stall = instr_valid && e_mem_en && !e_mem_wr && e_rd != '0 &&
			((d_uses1 && instr[19:15] == e_rd) || (d_uses2 && instr[24:20] == e_rd));
		if (exp_stall)
			stall_count++;
		check_ready(instr_ready, !exp_stall);
		check_fetch(pc_sel, flush_if, d_pc, d_flush);
		check_decode(imm_sel, br_op, illegal_instr, d_imm, d_br, d_ill);
		check_exe(a_sel_exe, b_sel_exe, alu_op_exe);
		check_mem(mem_en_mem, mem_wr_mem);
		check_wb(wb_sel_wb, reg_en_wb);
		check_fwd("fwd_a_sel", fwd_a_sel, expected_fwd(e_rs1));
		check_fwd("fwd_b_sel", fwd_b_sel, expected_fwd(e_rs2));
		advance_model(exp_stall || !instr_valid || d_ill, instr);
		ready = !exp_stall;
	endtask

	// Called 1 ns after a rising edge, returns at the same phase
	task automatic issue(input logic [INSTR_W-1:0] ins, input logic v, input logic bt);
		int   waited;
		logic accepted;
		instr       = ins;
		instr_valid = v;
		br_true     = bt;
		waited      = 0;
		accepted    = 1'b0;
		while (!accepted) begin
			if (waited == HOLD_LIMIT) begin
				stop_on_failure($sformatf("Timeout: instruction %h not accepted in %0d cycles",
					ins, HOLD_LIMIT));
			end else begin
				#1;
				check_cycle(accepted);
				@(posedge clk);
				#1;
				waited++;
			end
		end
	endtask

	// Registers limited to x0..x3 so hazards come up often
	task automatic gen_instr(output logic [INSTR_W-1:0] ins, output logic v, output logic bt);
		logic [31:0] r;
		logic [31:0] s;
		logic [6:0]  opc;
		logic [2:0]  f3;
		r = $random(seed);
		s = $random(seed);
		case (r[3:0])
			4'd0:                opc = OPC_LUI;
			4'd1:                opc = OPC_AUIPC;
			4'd2:                opc = OPC_JAL;
			4'd3:                opc = OPC_JALR;
			4'd4, 4'd5:          opc = OPC_BRANCH;
			4'd6, 4'd7, 4'd8:    opc = OPC_LOAD;
			4'd9, 4'd10:         opc = OPC_STORE;
			4'd11, 4'd12:        opc = OPC_IMM;
			4'd13, 4'd14:        opc = OPC_R;
			default:             opc = s[6:0];
		endcase
		f3 = r[7:5];
		if (opc == OPC_JALR && r[9:8] != 2'b11)
			f3 = 3'b000;
		ins = {s[31], r[16], s[29:25], 3'b000, r[15:14], 3'b000, r[13:12],
			f3, 3'b000, r[11:10], opc};
		v  = (r[19:17] != 3'b000);
		bt = r[20];
	endtask

	initial begin
		logic [INSTR_W-1:0] ins;
		logic               v;
		logic               bt;
		seed        = 63515;
		stall_count = 0;
		reset       = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		br_true     = 1'b0;
		reset_model();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int n = 0; n < NUM_INSTR; n++) begin
			gen_instr(ins, v, bt);
			issue(ins, v, bt);
		end
		if (stall_count == 0) begin
			stop_on_failure("No load-use stall occurred during the run");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

//--- build.f
hw/rv_ctrl_pkg.sv
hw/instr_decoder.sv
hw/hazard_unit.sv
hw/ctrl_pipe.sv
hw/pipeline_control.sv
sim/pipeline_control_assertions.sv
sim/pipeline_control_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = pipeline_control_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
